/* shim_pkg.sv */
// Async shim shared definitions
`default_nettype none

package shim_pkg;

   // tag carried with a read request and returned with its response
   localparam int TAG_WIDTH = 8;

   // line address of a read request
   localparam int ADDR_WIDTH = 32;

   // data word returned by the host
   localparam int DATA_WIDTH = 64;

   // the host may still accept this many requests after raising almost-full.
   // The credit margin on the response path is eight times this value
   localparam int ALMOST_FULL_THRESHOLD = 8;

   // read request crossing from afu_clk to bb_clk
   typedef struct packed {
      logic [TAG_WIDTH-1:0]  tag;
      logic [ADDR_WIDTH-1:0] addr;
   } req_t;

   // read response crossing from bb_clk to afu_clk
   typedef struct packed {
      logic [TAG_WIDTH-1:0]  tag;
      logic [DATA_WIDTH-1:0] data;
   } rsp_t;

endpackage

`default_nettype wire

/* async_fifo.sv */
// Dual-clock Gray pointer FIFO
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int DEPTH_RADIX = 6
) (
   input  wire                    wr_clk,
   input  wire                    rd_clk,
   input  wire                    bb_softreset,
   input  wire                    wr_en,
   input  wire payload_t          wr_data,
   output logic                   wr_full,
   output logic [DEPTH_RADIX-1:0] wr_used,
   input  wire                    rd_en,
   output payload_t               rd_data,
   output logic                   rd_empty
);

   localparam int DEPTH = 2 ** DEPTH_RADIX;

   payload_t mem [DEPTH];

   // pointers carry one extra bit to tell full from empty
   logic [DEPTH_RADIX:0] wr_bin;
   logic [DEPTH_RADIX:0] wr_bin_next;
   logic [DEPTH_RADIX:0] wr_gray;
   logic [DEPTH_RADIX:0] rd_bin;
   logic [DEPTH_RADIX:0] rd_bin_next;
   logic [DEPTH_RADIX:0] rd_gray;

   logic [DEPTH_RADIX:0] rd_gray_s1;
   logic [DEPTH_RADIX:0] rd_gray_s2;
   logic [DEPTH_RADIX:0] wr_gray_s1;
   logic [DEPTH_RADIX:0] wr_gray_s2;

   logic [DEPTH_RADIX:0] rd_bin_synced;
   logic [DEPTH_RADIX:0] wr_count;
   logic                 wr_push;

   function automatic logic [DEPTH_RADIX:0] bin_to_gray(input logic [DEPTH_RADIX:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [DEPTH_RADIX:0] gray_to_bin(input logic [DEPTH_RADIX:0] g);
      logic [DEPTH_RADIX:0] b;
      b[DEPTH_RADIX] = g[DEPTH_RADIX];
      for (int i = DEPTH_RADIX - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // a write that meets a full FIFO is dropped here
   assign wr_push     = wr_en & ~wr_full;
   assign wr_bin_next = wr_bin + 1'b1;
   assign rd_bin_next = rd_bin + 1'b1;

   always_ff @(posedge wr_clk) begin
      if (wr_push) begin
         mem[wr_bin[DEPTH_RADIX-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (bb_softreset) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         if (wr_push) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin_to_gray(wr_bin_next);
         end
      end
   end

   // full when the pointers differ only in their two top Gray bits
   assign wr_full = (wr_gray == {~rd_gray_s2[DEPTH_RADIX:DEPTH_RADIX-1],
                                 rd_gray_s2[DEPTH_RADIX-2:0]});

   assign rd_bin_synced = gray_to_bin(rd_gray_s2);
   assign wr_count      = wr_bin - rd_bin_synced;

   // the count only reaches DEPTH when full, so it saturates there
   assign wr_used = wr_count[DEPTH_RADIX] ? '1 : wr_count[DEPTH_RADIX-1:0];

   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_bin[DEPTH_RADIX-1:0]];
      end
   end

   always_ff @(posedge rd_clk) begin
      if (bb_softreset) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         if (rd_en) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin_to_gray(rd_bin_next);
         end
      end
   end

   assign rd_empty = (rd_gray == wr_gray_s2);

   // the reader must qualify its request with the empty flag
   a_no_read_when_empty : assert property (
      @(posedge rd_clk) disable iff (bb_softreset) rd_en |-> !rd_empty
   ) else $error("async_fifo read while empty");

   // the synchronized read pointer never runs ahead of the write pointer
   a_used_within_depth : assert property (
      @(posedge wr_clk) disable iff (bb_softreset) wr_count <= DEPTH
   ) else $error("async_fifo used count exceeds depth");

endmodule

`default_nettype wire

/* request_credit_counter.sv */
// Outstanding request credit counter
`timescale 1ns/1ps
`default_nettype none

module request_credit_counter #(
   parameter int RSP_DEPTH_RADIX = 7
) (
   input  wire                      afu_clk,
   input  wire                      afu_softreset,
   input  wire                      req_issued,
   input  wire                      rsp_returned,
   output logic [RSP_DEPTH_RADIX:0] outstanding
);

   // counts requests that have entered the shim and have no response yet

   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         outstanding <= '0;
      end else begin
         case ({req_issued, rsp_returned})
            2'b10: begin
               outstanding <= outstanding + 1'b1;
            end
            2'b01: begin
               outstanding <= outstanding - 1'b1;
            end
            default: begin
               // both or neither leave the count unchanged
               outstanding <= outstanding;
            end
         endcase
      end
   end

   // a response can only come back for a request that was counted
   a_no_underflow : assert property (
      @(posedge afu_clk) disable iff (afu_softreset)
         (rsp_returned && !req_issued) |-> (outstanding != '0)
   ) else $error("request credit counter decremented from zero");

endmodule

`default_nettype wire

/* request_channel.sv */
// Request path from afu_clk to bb_clk
`timescale 1ns/1ps
`default_nettype none

module request_channel #(
   parameter int REQ_DEPTH_RADIX = 6,
   parameter int RSP_DEPTH_RADIX = 7,
   parameter int EXTRA_PIPELINE  = 1
) (
   input  wire                 afu_clk,
   input  wire                 bb_clk,
   input  wire                 afu_softreset,
   input  wire                 bb_softreset,
   input  wire                 req_valid,
   input  wire shim_pkg::req_t req,
   input  wire                 rsp_returned,
   input  wire                 bb_tx_alm_full,
   output logic                bb_req_valid,
   output shim_pkg::req_t      bb_req,
   output logic                afu_tx_alm_full,
   output logic                overflow
);

   import shim_pkg::*;

   // responses still allowed in flight, leaving room for the requests that
   // arrive after almost-full and for the afu's own reaction time
   localparam int CREDIT_LIMIT = (2 ** RSP_DEPTH_RADIX) - ALMOST_FULL_THRESHOLD * 8;

   if (CREDIT_LIMIT <= 0) begin : g_credit_limit_check
      $fatal(1, "request_channel RSP_DEPTH_RADIX too small for the credit margin");
   end

   logic [REQ_DEPTH_RADIX-1:0] wr_used;
   logic                       wr_full;
   logic [RSP_DEPTH_RADIX:0]   outstanding;
   req_t                       rd_data;
   logic                       rd_empty;
   logic                       rd_empty_q;
   logic                       rd_req;
   logic                       rd_en;
   logic                       rd_valid;

   async_fifo #(
      .payload_t   (req_t),
      .DEPTH_RADIX (REQ_DEPTH_RADIX)
   ) u_req_fifo (
      .wr_clk       (afu_clk),
      .rd_clk       (bb_clk),
      .bb_softreset (bb_softreset),
      .wr_en        (req_valid),
      .wr_data      (req),
      .wr_full      (wr_full),
      .wr_used      (wr_used),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .rd_empty     (rd_empty)
   );

   request_credit_counter #(
      .RSP_DEPTH_RADIX (RSP_DEPTH_RADIX)
   ) u_credit_counter (
      .afu_clk       (afu_clk),
      .afu_softreset (afu_softreset),
      .req_issued    (req_valid),
      .rsp_returned  (rsp_returned),
      .outstanding   (outstanding)
   );

   // almost-full at half fill or when too many responses are pending
   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         afu_tx_alm_full <= 1'b0;
         overflow        <= 1'b0;
      end else begin
         afu_tx_alm_full <= wr_used[REQ_DEPTH_RADIX-1] ||
                            (outstanding > (RSP_DEPTH_RADIX+1)'(CREDIT_LIMIT));
         overflow        <= req_valid & wr_full;
      end
   end

   // the empty flag may take an extra register to ease bb_clk timing
   if (EXTRA_PIPELINE == 1) begin : g_empty_reg
      always_ff @(posedge bb_clk) begin
         if (bb_softreset) begin
            rd_empty_q <= 1'b1;
         end else begin
            rd_empty_q <= rd_empty;
         end
      end
   end else begin : g_empty_direct
      assign rd_empty_q = rd_empty;
   end

   // the stale empty flag can leave rd_req high, so the live flag guards the pop
   assign rd_en = rd_req & ~rd_empty;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         rd_req       <= 1'b0;
         rd_valid     <= 1'b0;
         bb_req_valid <= 1'b0;
      end else begin
         rd_req       <= ~bb_tx_alm_full & ~rd_empty_q;
         rd_valid     <= rd_en;
         bb_req_valid <= rd_valid;
      end
   end

   always_ff @(posedge bb_clk) begin
      bb_req <= rd_valid ? rd_data : '0;
   end

endmodule

`default_nettype wire

/* response_channel.sv */
// Response path from bb_clk to afu_clk
`timescale 1ns/1ps
`default_nettype none

module response_channel #(
   parameter int RSP_DEPTH_RADIX = 7
) (
   input  wire                 bb_clk,
   input  wire                 afu_clk,
   input  wire                 bb_softreset,
   input  wire                 afu_softreset,
   input  wire                 bb_rsp_valid,
   input  wire shim_pkg::rsp_t bb_rsp,
   output logic                afu_rsp_valid,
   output shim_pkg::rsp_t      afu_rsp,
   output logic                overflow
);

   import shim_pkg::*;

   logic                       wr_full;
   logic [RSP_DEPTH_RADIX-1:0] wr_used;
   rsp_t                       rd_data;
   logic                       rd_empty;
   logic                       rd_req;
   logic                       rd_en;
   logic                       rd_valid;
   logic                       ovf_toggle;
   logic [2:0]                 ovf_sync;

   async_fifo #(
      .payload_t   (rsp_t),
      .DEPTH_RADIX (RSP_DEPTH_RADIX)
   ) u_rsp_fifo (
      .wr_clk       (bb_clk),
      .rd_clk       (afu_clk),
      .bb_softreset (bb_softreset),
      .wr_en        (bb_rsp_valid),
      .wr_data      (bb_rsp),
      .wr_full      (wr_full),
      .wr_used      (wr_used),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .rd_empty     (rd_empty)
   );

   // a dropped response flips the toggle, and the afu side turns each flip
   // into a single pulse whatever the clock ratio
   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         ovf_toggle <= 1'b0;
      end else if (bb_rsp_valid && wr_full) begin
         ovf_toggle <= ~ovf_toggle;
      end
   end

   assign rd_en = rd_req & ~rd_empty;

   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         rd_req        <= 1'b0;
         rd_valid      <= 1'b0;
         afu_rsp_valid <= 1'b0;
         ovf_sync      <= '0;
      end else begin
         rd_req        <= ~rd_empty;
         rd_valid      <= rd_en;
         afu_rsp_valid <= rd_valid;
         ovf_sync      <= {ovf_sync[1:0], ovf_toggle};
      end
   end

   always_ff @(posedge afu_clk) begin
      afu_rsp <= rd_valid ? rd_data : '0;
   end

   assign overflow = ovf_sync[2] ^ ovf_sync[1];

   // the afu never sees a response begin while it is held in reset
   a_no_rsp_in_reset : assert property (
      @(posedge afu_clk) $rose(afu_rsp_valid) |-> !$past(afu_softreset)
   ) else $error("afu_rsp_valid rose during afu_softreset");

   // the depth must hold what the host sends after almost-full
   a_used_below_top : assert property (
      @(posedge bb_clk) disable iff (bb_softreset) bb_rsp_valid |-> !(&wr_used)
   ) else $error("response FIFO at capacity on a host response");

endmodule

`default_nettype wire

/* async_shim_top.sv */
// Clock crossing shim top level
`timescale 1ns/1ps
`default_nettype none

module async_shim_top #(
   parameter int REQ_DEPTH_RADIX = 6,
   parameter int RSP_DEPTH_RADIX = 7,
   parameter int EXTRA_PIPELINE  = 1
) (
   input  wire                             afu_clk,
   input  wire                             bb_clk,
   input  wire                             afu_req_valid,
   input  wire [shim_pkg::TAG_WIDTH-1:0]   afu_req_tag,
   input  wire [shim_pkg::ADDR_WIDTH-1:0]  afu_req_addr,
   output logic                            afu_rsp_valid,
   output logic [shim_pkg::TAG_WIDTH-1:0]  afu_rsp_tag,
   output logic [shim_pkg::DATA_WIDTH-1:0] afu_rsp_data,
   output logic                            afu_tx_alm_full,
   output logic                            afu_softreset,
   output logic [1:0]                      shim_error,
   input  wire                             bb_softreset,
   input  wire                             bb_tx_alm_full,
   input  wire                             bb_rsp_valid,
   input  wire [shim_pkg::TAG_WIDTH-1:0]   bb_rsp_tag,
   input  wire [shim_pkg::DATA_WIDTH-1:0]  bb_rsp_data,
   output logic                            bb_req_valid,
   output logic [shim_pkg::TAG_WIDTH-1:0]  bb_req_tag,
   output logic [shim_pkg::ADDR_WIDTH-1:0] bb_req_addr
);

   import shim_pkg::*;

   logic softreset_t1;
   logic softreset_t2;

   logic afu_req_valid_q;
   req_t afu_req_q;
   logic bb_rsp_valid_q;
   rsp_t bb_rsp_q;

   logic ch_bb_req_valid;
   req_t ch_bb_req;
   logic ch_alm_full;
   logic req_overflow;
   logic ch_rsp_valid;
   rsp_t ch_rsp;
   logic rsp_overflow;

   // three flops bring the host reset into afu_clk
   always_ff @(posedge afu_clk) begin
      softreset_t1  <= bb_softreset;
      softreset_t2  <= softreset_t1;
      afu_softreset <= softreset_t2;
   end

   // afu side input and output stages
   always_ff @(posedge afu_clk) begin
      if (afu_softreset) begin
         afu_req_valid_q <= 1'b0;
         afu_rsp_valid   <= 1'b0;
         afu_tx_alm_full <= 1'b0;
         shim_error      <= '0;
      end else begin
         afu_req_valid_q <= afu_req_valid;
         afu_rsp_valid   <= ch_rsp_valid;
         afu_tx_alm_full <= ch_alm_full;
         shim_error      <= {rsp_overflow, req_overflow};
      end
   end

   always_ff @(posedge afu_clk) begin
      afu_req_q.tag  <= afu_req_tag;
      afu_req_q.addr <= afu_req_addr;
      afu_rsp_tag    <= ch_rsp.tag;
      afu_rsp_data   <= ch_rsp.data;
   end

   // bb side input and output stages
   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         bb_rsp_valid_q <= 1'b0;
         bb_req_valid   <= 1'b0;
      end else begin
         bb_rsp_valid_q <= bb_rsp_valid;
         bb_req_valid   <= ch_bb_req_valid;
      end
   end

   always_ff @(posedge bb_clk) begin
      bb_rsp_q.tag  <= bb_rsp_tag;
      bb_rsp_q.data <= bb_rsp_data;
      bb_req_tag    <= ch_bb_req.tag;
      bb_req_addr   <= ch_bb_req.addr;
   end

   request_channel #(
      .REQ_DEPTH_RADIX (REQ_DEPTH_RADIX),
      .RSP_DEPTH_RADIX (RSP_DEPTH_RADIX),
      .EXTRA_PIPELINE  (EXTRA_PIPELINE)
   ) u_request_channel (
      .afu_clk         (afu_clk),
      .bb_clk          (bb_clk),
      .afu_softreset   (afu_softreset),
      .bb_softreset    (bb_softreset),
      .req_valid       (afu_req_valid_q),
      .req             (afu_req_q),
      .rsp_returned    (afu_rsp_valid),
      .bb_tx_alm_full  (bb_tx_alm_full),
      .bb_req_valid    (ch_bb_req_valid),
      .bb_req          (ch_bb_req),
      .afu_tx_alm_full (ch_alm_full),
      .overflow        (req_overflow)
   );

   response_channel #(
      .RSP_DEPTH_RADIX (RSP_DEPTH_RADIX)
   ) u_response_channel (
      .bb_clk        (bb_clk),
      .afu_clk       (afu_clk),
      .bb_softreset  (bb_softreset),
      .afu_softreset (afu_softreset),
      .bb_rsp_valid  (bb_rsp_valid_q),
      .bb_rsp        (bb_rsp_q),
      .afu_rsp_valid (ch_rsp_valid),
      .afu_rsp       (ch_rsp),
      .overflow      (rsp_overflow)
   );

endmodule

`default_nettype wire

/* tb_async_shim.sv */
// Async shim testbench
`timescale 1ns/1ps
`default_nettype none

module tb_async_shim;

   import shim_pkg::*;

   localparam int RSP_DEPTH_RADIX = 7;
   localparam int REQ_DEPTH_RADIX = 6;
   localparam int CREDIT_LIMIT    = (2 ** RSP_DEPTH_RADIX) - 8 * ALMOST_FULL_THRESHOLD;
   localparam int CREDIT_MARGIN   = 4;
   localparam int MAX_PACED       = 3;

   logic                  bb_clk;
   logic                  afu_clk;
   logic                  bb_softreset;
   logic                  afu_req_valid;
   logic [TAG_WIDTH-1:0]  afu_req_tag;
   logic [ADDR_WIDTH-1:0] afu_req_addr;
   logic                  afu_rsp_valid;
   logic [TAG_WIDTH-1:0]  afu_rsp_tag;
   logic [DATA_WIDTH-1:0] afu_rsp_data;
   logic                  afu_tx_alm_full;
   logic                  afu_softreset;
   logic [1:0]            shim_error;
   logic                  bb_tx_alm_full;
   logic                  bb_rsp_valid;
   logic [TAG_WIDTH-1:0]  bb_rsp_tag;
   logic [DATA_WIDTH-1:0] bb_rsp_data;
   logic                  bb_req_valid;
   logic [TAG_WIDTH-1:0]  bb_req_tag;
   logic [ADDR_WIDTH-1:0] bb_req_addr;

   integer seed;

   // reference queues for the two paths
   req_t req_expected [$];
   rsp_t rsp_expected [$];
   req_t req_head;
   rsp_t rsp_head;

   int   unanswered;
   int   paced_strobes;
   logic paced;
   int   overflow_pulses;
   logic overflow_test;

   always #50 bb_clk = ~bb_clk;
   always #35 afu_clk = ~afu_clk;

   async_shim_top UUT (
      .afu_clk         (afu_clk),
      .bb_clk          (bb_clk),
      .afu_req_valid   (afu_req_valid),
      .afu_req_tag     (afu_req_tag),
      .afu_req_addr    (afu_req_addr),
      .afu_rsp_valid   (afu_rsp_valid),
      .afu_rsp_tag     (afu_rsp_tag),
      .afu_rsp_data    (afu_rsp_data),
      .afu_tx_alm_full (afu_tx_alm_full),
      .afu_softreset   (afu_softreset),
      .shim_error      (shim_error),
      .bb_softreset    (bb_softreset),
      .bb_tx_alm_full  (bb_tx_alm_full),
      .bb_rsp_valid    (bb_rsp_valid),
      .bb_rsp_tag      (bb_rsp_tag),
      .bb_rsp_data     (bb_rsp_data),
      .bb_req_valid    (bb_req_valid),
      .bb_req_tag      (bb_req_tag),
      .bb_req_addr     (bb_req_addr)
   );

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   // the afu reset is released on the third afu edge after the host reset falls
   a_afu_reset_release : assert property (
      @(posedge afu_clk) $fell(bb_softreset) |-> ##2 afu_softreset ##1 !afu_softreset
   ) else stop_with_failure($sformatf("error at %0t ns: afu_softreset released off time",
                                      $time));

   // all outputs are quiet on the first afu edge out of reset
   a_idle_after_reset : assert property (
      @(posedge afu_clk) $fell(afu_softreset) |->
         (!bb_req_valid && !afu_rsp_valid && !afu_tx_alm_full && shim_error == 2'b00)
   ) else stop_with_failure($sformatf("error at %0t ns: outputs not idle after reset", $time));

   a_rsp_quiet_in_reset : assert property (
      @(posedge afu_clk) afu_softreset |=> !afu_rsp_valid
   ) else stop_with_failure($sformatf("error at %0t ns: afu_rsp_valid high in reset", $time));

   a_bb_req_payload_zero : assert property (
      @(posedge bb_clk) disable iff (bb_softreset)
         !bb_req_valid |-> (bb_req_tag == '0 && bb_req_addr == '0)
   ) else stop_with_failure($sformatf("error at %0t ns: bb_req payload not zero", $time));

   a_afu_rsp_payload_zero : assert property (
      @(posedge afu_clk) disable iff (afu_softreset !== 1'b0)
         !afu_rsp_valid |-> (afu_rsp_tag == '0 && afu_rsp_data == '0)
   ) else stop_with_failure($sformatf("error at %0t ns: afu_rsp payload not zero", $time));

   a_no_req_overflow : assert property (
      @(posedge afu_clk) disable iff (afu_softreset !== 1'b0 || overflow_test)
         !shim_error[0]
   ) else stop_with_failure($sformatf("error at %0t ns: request overflow pulse", $time));

   a_no_rsp_overflow : assert property (
      @(posedge afu_clk) disable iff (afu_softreset !== 1'b0) !shim_error[1]
   ) else stop_with_failure($sformatf("error at %0t ns: response overflow pulse", $time));

   // strobes on the bb side count as paced once almost-full was seen on an earlier edge
   always @(posedge bb_clk) begin
      if (bb_softreset === 1'b0) begin
         if (bb_tx_alm_full && !paced) begin
            paced_strobes = 0;
         end
         if (bb_req_valid) begin
            if (paced) begin
               paced_strobes = paced_strobes + 1;
            end
            assert (paced_strobes <= MAX_PACED)
               else stop_with_failure($sformatf("error at %0t ns: %0d requests after almost-full",
                                                $time, paced_strobes));
            assert (req_expected.size() > 0)
               else stop_with_failure("a request left the shim that was never sent");
            req_head = req_expected.pop_front();
            assert (bb_req_tag == req_head.tag && bb_req_addr == req_head.addr)
               else stop_with_failure($sformatf(
                  "error at %0t ns: bb_req %0h/%0h, expected %0h/%0h", $time,
                  bb_req_tag, bb_req_addr, req_head.tag, req_head.addr));
         end
      end
      paced = bb_tx_alm_full;
   end

   always @(posedge afu_clk) begin
      if (afu_softreset === 1'b0) begin
         if (afu_rsp_valid) begin
            assert (rsp_expected.size() > 0)
               else stop_with_failure("a response reached the afu that was never sent");
            rsp_head = rsp_expected.pop_front();
            assert (afu_rsp_tag == rsp_head.tag && afu_rsp_data == rsp_head.data)
               else stop_with_failure($sformatf(
                  "error at %0t ns: afu_rsp %0h/%0h, expected %0h/%0h", $time,
                  afu_rsp_tag, afu_rsp_data, rsp_head.tag, rsp_head.data));
            unanswered = unanswered - 1;
         end
         if (shim_error[0]) begin
            overflow_pulses = overflow_pulses + 1;
         end
      end
   end

   task automatic issue_requests(input int count, input bit expect_delivery,
                                 input bit check_credit);
      req_t item;
      for (int i = 0; i < count; i++) begin
         item.tag  = $random(seed);
         item.addr = $random(seed);
         @(negedge afu_clk);
         afu_req_valid = 1'b1;
         afu_req_tag   = item.tag;
         afu_req_addr  = item.addr;
         if (expect_delivery) begin
            req_expected.push_back(item);
         end
         unanswered = unanswered + 1;
         if (check_credit) begin
            assert (afu_tx_alm_full || unanswered <= CREDIT_LIMIT + CREDIT_MARGIN)
               else stop_with_failure($sformatf(
                  "error at %0t ns: afu_tx_alm_full low with %0d requests outstanding",
                  $time, unanswered));
         end
      end
      @(negedge afu_clk);
      afu_req_valid = 1'b0;
      afu_req_tag   = '0;
      afu_req_addr  = '0;
   endtask

   task automatic return_responses(input int count);
      rsp_t item;
      for (int i = 0; i < count; i++) begin
         item.tag  = $random(seed);
         item.data = {$random(seed), $random(seed)};
         @(negedge bb_clk);
         bb_rsp_valid = 1'b1;
         bb_rsp_tag   = item.tag;
         bb_rsp_data  = item.data;
         rsp_expected.push_back(item);
      end
      @(negedge bb_clk);
      bb_rsp_valid = 1'b0;
      bb_rsp_tag   = '0;
      bb_rsp_data  = '0;
   endtask

   task automatic wait_afu_reset_release();
      int cycles;
      cycles = 0;
      while (afu_softreset !== 1'b0) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > 20) stop_with_failure("timed out waiting for afu_softreset to fall");
      end
   endtask

   task automatic wait_requests_drained();
      int cycles;
      cycles = 0;
      while (req_expected.size() > 0) begin
         @(negedge bb_clk);
         cycles++;
         if (cycles > 300) stop_with_failure("timed out waiting for requests at the bb port");
      end
   endtask

   task automatic wait_responses_drained();
      int cycles;
      cycles = 0;
      while (rsp_expected.size() > 0) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > 300) stop_with_failure("timed out waiting for responses at the afu port");
      end
   endtask

   task automatic wait_alm_full_low();
      int cycles;
      cycles = 0;
      while (afu_tx_alm_full) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > 100) stop_with_failure("timed out waiting for afu_tx_alm_full to fall");
      end
   endtask

   task automatic wait_overflow_pulse();
      int cycles;
      cycles = 0;
      while (overflow_pulses == 0) begin
         @(negedge afu_clk);
         cycles++;
         if (cycles > 50) stop_with_failure("no request overflow pulse was seen");
      end
   endtask

   initial begin
      #1_000_000;
      stop_with_failure("simulation ran past its overall time limit");
   end

   initial begin
      seed            = 32'hc30d_58ef;
      bb_clk          = 1'b0;
      afu_clk         = 1'b0;
      bb_softreset    = 1'b1;
      bb_tx_alm_full  = 1'b0;
      bb_rsp_valid    = 1'b0;
      bb_rsp_tag      = '0;
      bb_rsp_data     = '0;
      afu_req_valid   = 1'b0;
      afu_req_tag     = '0;
      afu_req_addr    = '0;
      unanswered      = 0;
      paced_strobes   = 0;
      paced           = 1'b0;
      overflow_pulses = 0;
      overflow_test   = 1'b0;

      repeat (5) @(negedge bb_clk);
      bb_softreset = 1'b0;
      wait_afu_reset_release();

      // check request order and then return as many responses to clear the credit count
      issue_requests(40, 1'b1, 1'b0);
      wait_requests_drained();
      return_responses(40);
      wait_responses_drained();

      // hold host almost-full while the request FIFO still has entries
      issue_requests(30, 1'b1, 1'b0);
      @(negedge bb_clk);
      bb_tx_alm_full = 1'b1;
      repeat (20) @(negedge bb_clk);
      assert (req_expected.size() > 0)
         else stop_with_failure("requests kept flowing while host almost-full was high");
      bb_tx_alm_full = 1'b0;
      wait_requests_drained();
      return_responses(30);
      wait_responses_drained();

      // no responses come back, so the credit limit raises almost-full
      issue_requests(70, 1'b1, 1'b1);
      assert (afu_tx_alm_full)
         else stop_with_failure($sformatf("error at %0t ns: afu_tx_alm_full low", $time));
      return_responses(10);
      wait_alm_full_low();
      wait_requests_drained();
      wait_responses_drained();

      // push past the request FIFO depth while the host holds it back
      @(negedge afu_clk);
      overflow_test = 1'b1;
      @(negedge bb_clk);
      bb_tx_alm_full = 1'b1;
      repeat (5) @(negedge bb_clk);
      issue_requests((2 ** REQ_DEPTH_RADIX) + 8, 1'b0, 1'b0);
      wait_overflow_pulse();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
shim_pkg.sv
async_fifo.sv
request_credit_counter.sv
request_channel.sv
response_channel.sv
async_shim_top.sv
tb_async_shim.sv
